// File: src/sgd_pkg.sv
// sizes are fixed for 8 samples of 4-bit features per line; num_blocks of 0 selects all 16 words
package sgd_pkg;

    //////////////////////////////////////////////////
    // batch geometry
    //////////////////////////////////////////////////

    // one line = one bit plane of 8 features for 8 samples
    localparam int num_samples     = 8;
    localparam int feats_per_block = 8;
    localparam int plane_bits      = 4;
    localparam int plane_w         = $clog2(plane_bits);
    localparam int line_w          = num_samples * feats_per_block;

    // model words and arithmetic
    localparam int val_w      = 32;
    localparam int word_w     = feats_per_block * val_w;
    localparam int blk_depth  = 16;
    localparam int blk_addr_w = $clog2(blk_depth);

    // buffering, replay holds a full 16-block batch
    localparam int in_fifo_depth      = 16;
    localparam int replay_fifo_depth  = blk_depth * plane_bits;
    localparam int almost_full_margin = 4;

    typedef logic [line_w-1:0]       line_t;
    typedef logic signed [val_w-1:0] val_t;
    typedef logic [word_w-1:0]       word_t;
    typedef logic [blk_addr_w-1:0]   blk_addr_t;
    typedef logic [plane_w-1:0]      plane_t;

    //////////////////////////////////////////////////
    // fsm states
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        dp_idle,
        dp_run,
        dp_drain,
        dp_wait_update
    } dot_state_t;

    typedef enum logic [2:0] {
        gu_idle,
        gu_read_x,
        gu_accumulate,
        gu_write_x,
        gu_done
    } grad_state_t;

endpackage

// File: src/line_fifo.sv
`timescale 1ns/100ps
// rd_data is valid one cycle after rd_en; writer must honour almost_full, reader must check empty
module line_fifo
    import sgd_pkg::*;
#(
    parameter int depth = in_fifo_depth
)
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  wr_en,
    input  line_t wr_data,
    input  logic  rd_en,
    output line_t rd_data,
    output logic  rd_valid,
    output logic  empty,
    output logic  almost_full
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    line_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // wrap explicitly so odd depths work too
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty       = (count == '0);
    // margin covers writes already on their way
    assign almost_full = (count >= cnt_w'(depth - almost_full_margin));

    // storage and read register
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= wr_data;
        if (rd_en)
            rd_data <= mem[rd_ptr];
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_en;
            if (wr_en)
                wr_ptr <= next_ptr(wr_ptr);
            if (rd_en)
                rd_ptr <= next_ptr(rd_ptr);
            // occupancy only moves on a one-sided transfer
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producer ignored almost_full long enough to overflow
    assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> (count != cnt_w'(depth)) || rd_en);

    // consumer popped without checking empty
    assert property (@(posedge clk) disable iff (!arst_n)
        rd_en |-> !empty);

endmodule

// File: src/dot_product_unit.sv
`timescale 1ns/100ps
// num_blocks must stay stable for the whole batch; a value of 0 runs all 16 blocks
module dot_product_unit
    import sgd_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  blk_addr_t              num_blocks,
    output logic                   in_rd_en,
    input  line_t                  in_rd_data,
    input  logic                   in_rd_valid,
    input  logic                   in_empty,
    output logic                   x_rd_en,
    output blk_addr_t              x_rd_addr,
    input  word_t                  x_rd_data,
    output logic                   replay_wr_en,
    output line_t                  replay_wr_data,
    input  logic                   batch_done,
    output logic                   dot_valid,
    output val_t [num_samples-1:0] dot_products
);

    dot_state_t             state;
    blk_addr_t              blk;
    blk_addr_t              last_blk;
    logic [plane_w:0]       pops;
    plane_t                 plane;
    plane_t                 shift;
    logic                   last_line;
    val_t [num_samples-1:0] acc;
    val_t [num_samples-1:0] plane_sum;

    // 4-bit wrap makes 0 mean 16 blocks
    assign last_blk  = num_blocks - 1'b1;
    // msb plane arrives first, weight 3 down to 0
    assign shift     = plane_t'(plane_bits - 1) - plane;
    assign last_line = in_rd_valid && (plane == plane_t'(plane_bits - 1));

    // every accumulated line also goes to replay
    assign replay_wr_en   = in_rd_valid;
    assign replay_wr_data = in_rd_data;

    // pop the 4 lines of a block once its word is requested
    assign in_rd_en = (state == dp_run) && (pops != (plane_w + 1)'(plane_bits)) && !in_empty;

    //////////////////////////////////////////////////
    // model word requests
    //////////////////////////////////////////////////

    always_comb
    begin
        x_rd_en   = 1'b0;
        x_rd_addr = blk;
        if (state == dp_idle && !in_empty)
        begin
            // first line of a batch queued, fetch block 0
            x_rd_en   = 1'b1;
            x_rd_addr = '0;
        end
        else if (state == dp_run && last_line && blk != last_blk)
        begin
            // old word still seen by the last line this cycle
            x_rd_en   = 1'b1;
            x_rd_addr = blk + 1'b1;
        end
    end

    // per sample, sum of weights whose feature bit is set
    always_comb
    begin
        for (int s = 0; s < num_samples; s++)
        begin
            plane_sum[s] = '0;
            for (int f = 0; f < feats_per_block; f++)
            begin
                if (in_rd_data[s*feats_per_block + f])
                    plane_sum[s] = plane_sum[s] + val_t'(x_rd_data[f*val_w +: val_w]);
            end
        end
    end

    //////////////////////////////////////////////////
    // control fsm
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= dp_idle;
            blk       <= '0;
            pops      <= '0;
            plane     <= '0;
            dot_valid <= 1'b0;
        end
        else
        begin
            dot_valid <= 1'b0;
            case (state)
                dp_idle:
                    if (!in_empty)
                    begin
                        state <= dp_run;
                        blk   <= '0;
                        pops  <= '0;
                        plane <= '0;
                    end
                dp_run:
                begin
                    if (in_rd_en)
                        pops <= pops + 1'b1;
                    if (in_rd_valid)
                        plane <= plane + 1'b1;
                    if (last_line)
                    begin
                        pops <= '0;
                        if (blk == last_blk)
                            state <= dp_drain;
                        else
                            blk <= blk + 1'b1;
                    end
                end
                dp_drain:
                begin
                    dot_valid <= 1'b1;
                    state     <= dp_wait_update;
                end
                // next batch waits in the input fifo
                default:
                    if (batch_done)
                        state <= dp_idle;
            endcase
        end
    end

    // accumulators and result register
    always_ff @(posedge clk)
    begin
        if (state == dp_idle)
            acc <= '0;
        else if (state == dp_run && in_rd_valid)
            for (int s = 0; s < num_samples; s++)
                acc[s] <= acc[s] + (plane_sum[s] <<< shift);
        if (state == dp_drain)
            dot_products <= acc;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(dot_valid) |-> $past(state == dp_drain));

endmodule

// File: src/gradient_update.sv
`timescale 1ns/100ps
// loss values arrive pre-scaled by the step size; model elements wrap at 32 bits
module gradient_update
    import sgd_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  blk_addr_t              num_blocks,
    input  logic                   dot_valid,
    input  logic                   loss_valid,
    input  val_t [num_samples-1:0] loss_values,
    output logic                   loss_ready,
    output logic                   replay_rd_en,
    input  line_t                  replay_rd_data,
    input  logic                   replay_rd_valid,
    output logic                   x_rd_en,
    output blk_addr_t              x_rd_addr,
    input  word_t                  x_rd_data,
    output logic                   x_wr_en,
    output blk_addr_t              x_wr_addr,
    output word_t                  x_wr_data,
    output logic                   batch_done
);

    grad_state_t                state;
    logic                       armed;
    blk_addr_t                  blk;
    blk_addr_t                  last_blk;
    logic [plane_w:0]           pops;
    plane_t                     plane;
    plane_t                     shift;
    val_t [num_samples-1:0]     loss;
    val_t [feats_per_block-1:0] grad;
    val_t [feats_per_block-1:0] plane_sum;

    assign last_blk = num_blocks - 1'b1;
    assign shift    = plane_t'(plane_bits - 1) - plane;

    // armed between dot_valid and the loss transfer
    assign loss_ready = (state == gu_idle) && armed;

    // one model port access per phase, block index as address
    assign x_rd_en    = (state == gu_read_x);
    assign x_rd_addr  = blk;
    assign x_wr_en    = (state == gu_write_x);
    assign x_wr_addr  = blk;
    assign batch_done = (state == gu_done);

    assign replay_rd_en = (state == gu_accumulate) && (pops != (plane_w + 1)'(plane_bits));

    // per feature, loss summed over samples with the bit set
    always_comb
    begin
        for (int f = 0; f < feats_per_block; f++)
        begin
            plane_sum[f] = '0;
            for (int s = 0; s < num_samples; s++)
            begin
                if (replay_rd_data[s*feats_per_block + f])
                    plane_sum[f] = plane_sum[f] + loss[s];
            end
        end
    end

    // x minus gradient, word held since read_x
    always_comb
    begin
        for (int f = 0; f < feats_per_block; f++)
            x_wr_data[f*val_w +: val_w] = val_t'(x_rd_data[f*val_w +: val_w]) - grad[f];
    end

    //////////////////////////////////////////////////
    // update fsm
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= gu_idle;
            armed <= 1'b0;
            blk   <= '0;
            pops  <= '0;
            plane <= '0;
        end
        else
        begin
            case (state)
                gu_idle:
                begin
                    if (dot_valid)
                        armed <= 1'b1;
                    if (loss_valid && loss_ready)
                    begin
                        armed <= 1'b0;
                        blk   <= '0;
                        state <= gu_read_x;
                    end
                end
                gu_read_x:
                begin
                    pops  <= '0;
                    plane <= '0;
                    state <= gu_accumulate;
                end
                gu_accumulate:
                begin
                    if (replay_rd_en)
                        pops <= pops + 1'b1;
                    if (replay_rd_valid)
                    begin
                        plane <= plane + 1'b1;
                        // 4th plane lands this cycle
                        if (plane == plane_t'(plane_bits - 1))
                            state <= gu_write_x;
                    end
                end
                gu_write_x:
                    if (blk == last_blk)
                        state <= gu_done;
                    else
                    begin
                        blk   <= blk + 1'b1;
                        state <= gu_read_x;
                    end
                default:
                    state <= gu_idle;
            endcase
        end
    end

    // loss latch and gradient accumulators
    always_ff @(posedge clk)
    begin
        if (loss_valid && loss_ready)
            loss <= loss_values;
        if (state == gu_read_x)
            grad <= '0;
        else if (state == gu_accumulate && replay_rd_valid)
            for (int f = 0; f < feats_per_block; f++)
                grad[f] <= grad[f] + (plane_sum[f] <<< shift);
    end

    // loss is only offered once the dot products are out
    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(loss_ready) |-> $past(dot_valid) || $past(armed));

endmodule

// File: src/model_store.sv
`timescale 1ns/100ps
// no reset here; host_rd_en must be held low for 2 clocks before host_rd_valid is trusted
module model_store
    import sgd_pkg::*;
(
    input  logic      clk,
    input  logic      host_wr_en,
    input  blk_addr_t host_addr,
    input  word_t     host_wr_data,
    input  logic      host_rd_en,
    output word_t     host_rd_data,
    output logic      host_rd_valid,
    input  logic      dp_rd_en,
    input  blk_addr_t dp_rd_addr,
    input  logic      gu_rd_en,
    input  blk_addr_t gu_rd_addr,
    output word_t     eng_rd_data,
    input  logic      gu_wr_en,
    input  blk_addr_t gu_wr_addr,
    input  word_t     gu_wr_data
);

    word_t     mem [blk_depth];
    logic      wr_en;
    blk_addr_t wr_addr;
    word_t     wr_data;
    logic      rd_en;
    blk_addr_t rd_addr;
    logic      host_rd_q;

    //////////////////////////////////////////////////
    // port selection
    //////////////////////////////////////////////////

    always_comb
    begin
        // host writes only while the engine is idle
        wr_en   = host_wr_en || gu_wr_en;
        wr_addr = host_wr_en ? host_addr : gu_wr_addr;
        wr_data = host_wr_en ? host_wr_data : gu_wr_data;
        // engine units first, host readback last
        rd_en   = dp_rd_en || gu_rd_en || host_rd_en;
        if (dp_rd_en)
            rd_addr = dp_rd_addr;
        else if (gu_rd_en)
            rd_addr = gu_rd_addr;
        else
            rd_addr = host_addr;
    end

    // read data holds until the next read
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        if (rd_en)
            eng_rd_data <= mem[rd_addr];
    end

    // extra stage on the host side, 2 cycle readback
    always_ff @(posedge clk)
    begin
        host_rd_q     <= host_rd_en;
        host_rd_valid <= host_rd_q;
        if (host_rd_q)
            host_rd_data <= eng_rd_data;
    end

    // dot and gradient phases never overlap
    assert property (@(posedge clk) !(dp_rd_en && gu_rd_en));

endmodule

// File: src/bw_sgd_top.sv
`timescale 1ns/100ps
// num_blocks of 0 means 16 blocks; host model port only between batch_done and the next first line
module bw_sgd_top
    import sgd_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   line_wr_en,
    input  line_t                  line_data,
    output logic                   line_almost_full,
    input  blk_addr_t              num_blocks,
    output logic                   dot_valid,
    output val_t [num_samples-1:0] dot_products,
    input  logic                   loss_valid,
    input  val_t [num_samples-1:0] loss_values,
    output logic                   loss_ready,
    output logic                   batch_done,
    input  logic                   host_wr_en,
    input  blk_addr_t              host_addr,
    input  word_t                  host_wr_data,
    input  logic                   host_rd_en,
    output word_t                  host_rd_data,
    output logic                   host_rd_valid
);

    // input fifo to dot product
    logic      in_rd_en;
    line_t     in_rd_data;
    logic      in_rd_valid;
    logic      in_empty;
    // replay path
    logic      replay_wr_en;
    line_t     replay_wr_data;
    logic      replay_rd_en;
    line_t     replay_rd_data;
    logic      replay_rd_valid;
    // model store engine side
    logic      dp_rd_en;
    blk_addr_t dp_rd_addr;
    logic      gu_rd_en;
    blk_addr_t gu_rd_addr;
    word_t     eng_rd_data;
    logic      gu_wr_en;
    blk_addr_t gu_wr_addr;
    word_t     gu_wr_data;

    //////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////

    line_fifo #(
        .depth       (in_fifo_depth)
    ) in_fifo (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_en       (line_wr_en),
        .wr_data     (line_data),
        .rd_en       (in_rd_en),
        .rd_data     (in_rd_data),
        .rd_valid    (in_rd_valid),
        .empty       (in_empty),
        .almost_full (line_almost_full)
    );

    // sized for a whole batch, flags left open
    line_fifo #(
        .depth       (replay_fifo_depth)
    ) replay_fifo (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_en       (replay_wr_en),
        .wr_data     (replay_wr_data),
        .rd_en       (replay_rd_en),
        .rd_data     (replay_rd_data),
        .rd_valid    (replay_rd_valid),
        .empty       (),
        .almost_full ()
    );

    //////////////////////////////////////////////////
    // processing
    //////////////////////////////////////////////////

    dot_product_unit u_dot (
        .clk            (clk),
        .arst_n         (arst_n),
        .num_blocks     (num_blocks),
        .in_rd_en       (in_rd_en),
        .in_rd_data     (in_rd_data),
        .in_rd_valid    (in_rd_valid),
        .in_empty       (in_empty),
        .x_rd_en        (dp_rd_en),
        .x_rd_addr      (dp_rd_addr),
        .x_rd_data      (eng_rd_data),
        .replay_wr_en   (replay_wr_en),
        .replay_wr_data (replay_wr_data),
        .batch_done     (batch_done),
        .dot_valid      (dot_valid),
        .dot_products   (dot_products)
    );

    gradient_update u_grad (
        .clk             (clk),
        .arst_n          (arst_n),
        .num_blocks      (num_blocks),
        .dot_valid       (dot_valid),
        .loss_valid      (loss_valid),
        .loss_values     (loss_values),
        .loss_ready      (loss_ready),
        .replay_rd_en    (replay_rd_en),
        .replay_rd_data  (replay_rd_data),
        .replay_rd_valid (replay_rd_valid),
        .x_rd_en         (gu_rd_en),
        .x_rd_addr       (gu_rd_addr),
        .x_rd_data       (eng_rd_data),
        .x_wr_en         (gu_wr_en),
        .x_wr_addr       (gu_wr_addr),
        .x_wr_data       (gu_wr_data),
        .batch_done      (batch_done)
    );

    model_store u_store (
        .clk           (clk),
        .host_wr_en    (host_wr_en),
        .host_addr     (host_addr),
        .host_wr_data  (host_wr_data),
        .host_rd_en    (host_rd_en),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid),
        .dp_rd_en      (dp_rd_en),
        .dp_rd_addr    (dp_rd_addr),
        .gu_rd_en      (gu_rd_en),
        .gu_rd_addr    (gu_rd_addr),
        .eng_rd_data   (eng_rd_data),
        .gu_wr_en      (gu_wr_en),
        .gu_wr_addr    (gu_wr_addr),
        .gu_wr_data    (gu_wr_data)
    );

endmodule

// File: tests/tb_clock.sv
// 10 ns clock from time 0; arst_n held low for 8 rising edges, released 1 ns after the 8th
`timescale 1ns/100ps
module tb_clock
(
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // release lines up with the stimulus offset
    initial
    begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

// File: tests/bw_sgd_tb.sv
// drives at 1 ns after posedge and samples there too; back-to-back batches share one num_blocks
`timescale 1ns/100ps
module bw_sgd_tb
    import sgd_pkg::*;
;

    // 16 single batches plus 3 groups of 4 back-to-back batches
    localparam int group_count   = 3;
    localparam int group_size    = 4;
    localparam int total_batches = blk_depth + group_count * group_size;
    localparam int max_lines     = blk_depth * plane_bits;
    // dot and gradient phases, loss delay, preload and readback of all words
    localparam int batch_budget   = 4 * max_lines + 8 + 4 * blk_depth;
    localparam int timeout_cycles = total_batches * batch_budget + 500;

    logic                   clk;
    logic                   arst_n;
    logic                   line_wr_en;
    line_t                  line_data;
    logic                   line_almost_full;
    blk_addr_t              num_blocks;
    logic                   dot_valid;
    val_t [num_samples-1:0] dot_products;
    logic                   loss_valid;
    val_t [num_samples-1:0] loss_values;
    logic                   loss_ready;
    logic                   batch_done;
    logic                   host_wr_en;
    blk_addr_t              host_addr;
    word_t                  host_wr_data;
    logic                   host_rd_en;
    word_t                  host_rd_data;
    logic                   host_rd_valid;

    // reference state
    val_t                   xm [blk_depth][feats_per_block];
    line_t                  lines_q [$];
    val_t [num_samples-1:0] loss_q [$];
    logic [31:0]            lfsr = 32'hcecd;
    logic                   af_seen = 1'b0;
    int                     cycles = 0;

    tb_clock clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    bw_sgd_top dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .line_wr_en       (line_wr_en),
        .line_data        (line_data),
        .line_almost_full (line_almost_full),
        .num_blocks       (num_blocks),
        .dot_valid        (dot_valid),
        .dot_products     (dot_products),
        .loss_valid       (loss_valid),
        .loss_values      (loss_values),
        .loss_ready       (loss_ready),
        .batch_done       (batch_done),
        .host_wr_en       (host_wr_en),
        .host_addr        (host_addr),
        .host_wr_data     (host_wr_data),
        .host_rd_en       (host_rd_en),
        .host_rd_data     (host_rd_data),
        .host_rd_valid    (host_rd_valid)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // galois lfsr stepped once per output bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("error @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_val(input string what, input val_t got, input val_t exp);
        if (got !== exp)
        begin
            $display("error @ %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // 4-bit feature rebuilt from planes with the msb plane first
    function automatic int feature_value(input int base, input int s, input int f);
        int v;
        v = 0;
        for (int p = 0; p < plane_bits; p++)
            v = v * 2 + int'(lines_q[base + p][s*feats_per_block + f]);
        return v;
    endfunction

    function automatic val_t expected_dot(input int base, input int nb, input int s);
        val_t sum;
        sum = '0;
        for (int b = 0; b < nb; b++)
            for (int f = 0; f < feats_per_block; f++)
                sum = sum + val_t'(feature_value(base + b*plane_bits, s, f)) * xm[b][f];
        return sum;
    endfunction

    // x minus sum of loss times feature with 32-bit wrap
    task automatic apply_update(input int base, input int nb,
                                input val_t [num_samples-1:0] lv);
        val_t g;
        for (int b = 0; b < nb; b++)
            for (int f = 0; f < feats_per_block; f++)
            begin
                g = '0;
                for (int s = 0; s < num_samples; s++)
                    g = g + lv[s] * val_t'(feature_value(base + b*plane_bits, s, f));
                xm[b][f] = xm[b][f] - g;
            end
    endtask

    function automatic word_t model_word(input int a);
        word_t w;
        for (int f = 0; f < feats_per_block; f++)
            w[f*val_w +: val_w] = xm[a][f];
        return w;
    endfunction

    //////////////////////////////////////////////////
    // host model port
    //////////////////////////////////////////////////

    task automatic preload_model();
        word_t w;
        for (int a = 0; a < blk_depth; a++)
        begin
            for (int f = 0; f < feats_per_block; f++)
            begin
                w[f*val_w +: val_w] = next_bits(32);
                xm[a][f]            = val_t'(w[f*val_w +: val_w]);
            end
            host_wr_en   = 1'b1;
            host_addr    = blk_addr_t'(a);
            host_wr_data = w;
            step();
        end
        host_wr_en = 1'b0;
    endtask

    // valid must appear exactly 2 cycles after the request
    task automatic read_back_all(input string tag);
        for (int a = 0; a < blk_depth; a++)
        begin
            host_rd_en = 1'b1;
            host_addr  = blk_addr_t'(a);
            step();
            host_rd_en = 1'b0;
            check_flag("host_rd_valid 1 cycle after request", host_rd_valid, 1'b0);
            step();
            check_flag("host_rd_valid 2 cycles after request", host_rd_valid, 1'b1);
            check_word($sformatf("%s model word %0d", tag, a), host_rd_data, model_word(a));
        end
    endtask

    //////////////////////////////////////////////////
    // batch traffic
    //////////////////////////////////////////////////

    // lines stream as fast as almost_full allows while loss follows a random delay
    task automatic run_group(input int n_batches, input int nb);
        int                     next_line;
        int                     dot_idx;
        int                     done_idx;
        int                     delay;
        logic [31:0]            r;
        val_t [num_samples-1:0] lv;
        lines_q.delete();
        loss_q.delete();
        for (int i = 0; i < n_batches * nb * plane_bits; i++)
            lines_q.push_back({next_bits(32), next_bits(32)});
        num_blocks = blk_addr_t'(nb);
        next_line  = 0;
        dot_idx    = 0;
        done_idx   = 0;
        delay      = int'(next_bits(3));
        while (done_idx < n_batches)
        begin
            step();
            if (dot_valid)
            begin
                // model must already hold the previous update
                if (dot_idx != done_idx || dot_idx >= n_batches)
                begin
                    $display("dot_valid came before the previous batch finished");
                    abort_run();
                end
                for (int s = 0; s < num_samples; s++)
                    check_val($sformatf("nb %0d batch %0d dot product %0d", nb, dot_idx, s),
                              dot_products[s],
                              expected_dot(dot_idx * nb * plane_bits, nb, s));
                dot_idx++;
            end
            if (batch_done)
            begin
                if (done_idx >= loss_q.size())
                begin
                    $display("batch_done came before the loss of that batch was sent");
                    abort_run();
                end
                apply_update(done_idx * nb * plane_bits, nb, loss_q[done_idx]);
                done_idx++;
            end
            // write only on a sampled low almost_full
            line_wr_en = 1'b0;
            if (line_almost_full)
                af_seen = 1'b1;
            else if (next_line < lines_q.size())
            begin
                line_wr_en = 1'b1;
                line_data  = lines_q[next_line];
                next_line++;
            end
            // ready belongs to the one batch whose dot products are out and whose loss is not
            if (loss_ready && dot_idx != loss_q.size() + 1)
            begin
                $display("loss_ready was high outside the window from dot_valid to the loss");
                abort_run();
            end
            // ready stays high until the transfer, so one cycle of valid is enough
            loss_valid = 1'b0;
            if (loss_ready)
            begin
                if (delay == 0)
                begin
                    for (int s = 0; s < num_samples; s++)
                    begin
                        r     = next_bits(16);
                        lv[s] = val_t'({{16{r[15]}}, r[15:0]});
                    end
                    loss_q.push_back(lv);
                    loss_values = lv;
                    loss_valid  = 1'b1;
                    delay       = int'(next_bits(3));
                end
                else
                    delay--;
            end
        end
        line_wr_en = 1'b0;
        loss_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles)
        begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            abort_run();
        end
    end

    initial
    begin
        int nb;
        line_wr_en   = 1'b0;
        line_data    = '0;
        num_blocks   = blk_addr_t'(1);
        loss_valid   = 1'b0;
        loss_values  = '0;
        host_wr_en   = 1'b0;
        host_addr    = '0;
        host_wr_data = '0;
        host_rd_en   = 1'b0;
        wait (arst_n === 1'b1);
        step();

        // quiet outputs out of reset
        check_flag("line_almost_full after reset", line_almost_full, 1'b0);
        check_flag("dot_valid after reset", dot_valid, 1'b0);
        check_flag("loss_ready after reset", loss_ready, 1'b0);
        check_flag("batch_done after reset", batch_done, 1'b0);
        check_flag("host_rd_valid after reset", host_rd_valid, 1'b0);

        preload_model();
        read_back_all("preload");

        // single batches over every block count
        for (int n = 1; n <= blk_depth; n++)
        begin
            run_group(1, n);
            read_back_all($sformatf("after nb %0d", n));
        end

        // back-to-back batches with enough lines to fill the input fifo
        af_seen = 1'b0;
        for (int g = 0; g < group_count; g++)
        begin
            nb = 4 + int'(next_bits(4)) % (blk_depth - 3);
            run_group(group_size, nb);
        end
        read_back_all("after back-to-back groups");
        if (!af_seen)
        begin
            $display("line_almost_full never rose while batches were queued back-to-back");
            abort_run();
        end
        else
        begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: all.f
src/sgd_pkg.sv
src/line_fifo.sv
src/dot_product_unit.sv
src/gradient_update.sv
src/model_store.sv
src/bw_sgd_top.sv
tests/tb_clock.sv
tests/bw_sgd_tb.sv
